//--- all.f
common/dcu_pkg.sv
dcache/byte_lane_align.sv
dcache/dcu.sv
hdl/axi_sram.sv
hdl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run for the load/store data path

VERILATOR  ?= verilator
TOP        ?= tb_mem_subsys
RTL_TOP    ?= mem_subsys_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "run ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
  import dcu_pkg::*;
();

  localparam int NUM_ITER       = 400;
  localparam int WIN_WORDS      = 8;     // words touched in each window
  localparam int CACHED_FIRST   = 512;   // first cacheable word index
  localparam int NUM_INIT       = 2 * WIN_WORDS;
  localparam int MAX_REQ        = NUM_INIT + 2 * NUM_ITER;
  localparam int TIMEOUT_CYCLES = MAX_REQ * 40 + 100;

  logic     clock;
  logic     reset;
  lsu_req_t req;
  logic     req_valid;
  logic     req_ready;
  lsu_rsp_t rsp;
  logic     rsp_valid;
  logic     rsp_ready;

  integer seed;

  logic [7:0] model_mem [4*MEM_WORDS];  // indexed by address bits 11:0

  // model copy of the line bookkeeping
  logic        line_valid;
  logic [29:0] line_tag;
  logic [3:0]  line_held;

  mem_subsys_top dut0 (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  always #10 clock = ~clock;

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("watchdog expired, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic compare_rsp(input string name, input lsu_rsp_t exp, input lsu_rsp_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp.rdata, act.rdata);
      $display("Simulation failed");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "handshake mismatch");
    end
  endtask

  function automatic logic [3:0] byte_mask(input logic [1:0] off, input mem_size_e size);
    logic [3:0] m;
    m = '0;
    for (int b = 0; b < (1 << int'(size)); b++) m[off + b] = 1'b1;
    return m;
  endfunction

  function automatic logic [31:0] model_load(input logic [31:0] addr, input mem_size_e size);
    logic [31:0] d;
    d = '0;  // zero extension
    for (int b = 0; b < (1 << int'(size)); b++) d[8*b +: 8] = model_mem[addr[11:0] + b];
    return d;
  endfunction

  function automatic void model_store(input logic [31:0] addr, input mem_size_e size,
                                      input logic [31:0] wdata);
    for (int b = 0; b < (1 << int'(size)); b++) model_mem[addr[11:0] + b] = wdata[8*b +: 8];
  endfunction

  function automatic bit predict_hit(input lsu_req_t r);
    bit         tag_eq;
    logic [3:0] need;
    tag_eq = line_valid && (line_tag == r.addr[31:2]);
    need   = byte_mask(r.addr[1:0], r.size);
    if (r.addr < CACHE_BASE) return 1'b0;
    if (r.op == OP_LOAD) return tag_eq && ((need & ~line_held) == 4'b0000);
    if (r.op == OP_STORE) return tag_eq || !line_valid;
    return 1'b0;
  endfunction

  function automatic void update_line(input lsu_req_t r, input bit hit);
    logic [3:0] need;
    need = byte_mask(r.addr[1:0], r.size);
    if (r.op == OP_FLUSH) begin
      line_valid = 1'b0;
      line_held  = 4'b0000;
    end else if (r.addr >= CACHE_BASE) begin
      if (r.op == OP_LOAD && !hit) begin
        line_held = 4'b1111;  // full word filled
      end else if (r.op == OP_STORE) begin
        line_held = hit ? (line_held | need) : need;
      end
      line_valid = 1'b1;
      line_tag   = r.addr[31:2];
    end
  endfunction

  // one request through acceptance, response and back-pressure
  task automatic issue_and_check(input string name, input lsu_req_t r);
    lsu_rsp_t exp_rsp;
    lsu_rsp_t first;
    bit       hit;
    bit       seen;
    bit       taken;
    int       gap;
    int       stall;

    hit           = predict_hit(r);
    exp_rsp.rdata = (r.op == OP_LOAD) ? model_load(r.addr, r.size) : 32'h0;
    if (r.op == OP_STORE) model_store(r.addr, r.size, r.wdata);
    update_line(r, hit);

    gap   = $random(seed) & 3;
    stall = (($random(seed) & 3) == 0) ? ($random(seed) & 7) + 1 : 0;

    repeat (gap) @(posedge clock);
    req       <= r;
    req_valid <= 1'b1;
    rsp_ready <= (stall == 0);
    do begin
      @(negedge clock);
      seen = req_ready;
      @(posedge clock);
    end while (!seen);
    req_valid <= 1'b0;  // accepted on this edge
    req       <= '0;

    @(negedge clock);
    if (hit) compare_bit({name, " hit latency"}, 1'b1, rsp_valid);
    while (!rsp_valid) @(negedge clock);

    first = rsp;
    compare_rsp(name, exp_rsp, first);
    taken = 1'b0;
    while (!taken) begin
      compare_rsp({name, " held response"}, first, rsp);
      compare_bit({name, " req_ready while responding"}, 1'b0, req_ready);
      compare_bit({name, " rsp_valid held"}, 1'b1, rsp_valid);
      taken = rsp_ready;
      @(posedge clock);
      if (!taken) begin
        stall = stall - 1;
        if (stall <= 0) rsp_ready <= 1'b1;
        @(negedge clock);
      end
    end
  endtask

  task automatic random_access(input bit cached);
    lsu_req_t   r;
    int         word;
    logic [1:0] off;
    logic [1:0] align;
    word   = $random(seed) & (WIN_WORDS - 1);
    r.op   = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
    r.size = mem_size_e'(($random(seed) & 255) % 3);
    align  = (r.size == SZ_BYTE) ? 2'b11 : (r.size == SZ_HALF) ? 2'b10 : 2'b00;
    off    = 2'($random(seed)) & align;
    if (cached) begin
      r.addr = CACHE_BASE | 32'((CACHED_FIRST + word) * 4) | {30'h0, off};
    end else begin
      r.addr = 32'(word * 4) | {30'h0, off};
    end
    r.wdata = $random(seed);  // upper lanes are don't care
    issue_and_check($sformatf("%s %s @%h", cached ? "cached" : "uncached",
                              r.op == OP_STORE ? "store" : "load", r.addr), r);
  endtask

  // flush the line and read the alias straight from memory
  task automatic flush_and_alias();
    lsu_req_t r;
    int       word;
    word    = $random(seed) & (WIN_WORDS - 1);
    if (line_valid) begin
      word = int'(line_tag[MEM_IDX_W-1:0]) - CACHED_FIRST;  // the word being written back
    end
    r       = '0;
    r.op    = OP_FLUSH;
    r.size  = SZ_WORD;
    r.addr  = CACHE_BASE;
    issue_and_check("flush", r);
    r.op    = OP_LOAD;
    r.addr  = 32'((CACHED_FIRST + word) * 4);
    issue_and_check($sformatf("alias load @%h after flush", r.addr), r);
  endtask

  initial begin
    lsu_req_t r;
    int       kind;

    seed       = 31;
    clock      = 1'b0;
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b0;
    line_valid = 1'b0;
    line_tag   = '0;
    line_held  = 4'b0000;

    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_bit("req_ready after reset", 1'b1, req_ready);
    compare_bit("rsp_valid after reset", 1'b0, rsp_valid);
    @(posedge clock);

    // preload both windows through uncached word stores
    for (int w = 0; w < WIN_WORDS; w++) begin
      r       = '0;
      r.op    = OP_STORE;
      r.size  = SZ_WORD;
      r.addr  = 32'((CACHED_FIRST + w) * 4);
      r.wdata = r.addr * 32'h9e37_79b1 + 32'h1234_5678;
      issue_and_check("preload cached window", r);
      r.addr  = 32'(w * 4);
      r.wdata = r.addr * 32'h9e37_79b1 + 32'h1234_5678;
      issue_and_check("preload uncached window", r);
    end

    for (int i = 0; i < NUM_ITER; i++) begin
      kind = $random(seed) & 15;
      if (kind < 9) begin
        random_access(1'b1);
      end else if (kind < 11) begin
        flush_and_alias();
      end else begin
        random_access(1'b0);
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- hdl/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top
  import dcu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  lsu_req_t req,
  input  logic     req_valid,
  output logic     req_ready,
  output lsu_rsp_t rsp,
  output logic     rsp_valid,
  input  logic     rsp_ready
);

  axi_req_t axi_req;   // dcu to memory
  axi_rsp_t axi_rsp;

  dcu u_dcu (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .axi_req   (axi_req),
    .axi_rsp   (axi_rsp)
  );

  // on-chip backing store
  axi_sram u_sram (
    .clock   (clock),
    .reset   (reset),
    .axi_req (axi_req),
    .axi_rsp (axi_rsp)
  );

endmodule

//--- hdl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram
  import dcu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  axi_req_t axi_req,
  output axi_rsp_t axi_rsp
);

  logic [XLEN-1:0] mem [MEM_WORDS];

  logic                  busy;      // one access in flight
  logic                  wr_q;
  logic [MEM_IDX_W-1:0]  idx_q;
  logic [SRAM_CNT_W-1:0] cnt;
  logic                  b_valid_q;
  logic                  r_valid_q;
  logic [XLEN-1:0]       r_data_q;

  logic                 aw_w_both;
  logic                 wr_go;
  logic                 rd_go;
  logic [MEM_IDX_W-1:0] wr_idx;
  logic [MEM_IDX_W-1:0] rd_idx;

  assign aw_w_both = axi_req.aw_valid && axi_req.w_valid;

  // writes win if both show up together
  assign wr_go = !busy && aw_w_both;
  assign rd_go = !busy && axi_req.ar_valid && !aw_w_both;

  // upper address bits ignored, so aliases map to the same word
  assign wr_idx = axi_req.aw_addr[MEM_IDX_W+1:2];
  assign rd_idx = axi_req.ar_addr[MEM_IDX_W+1:2];

  // address and data only accepted together
  assign axi_rsp.aw_ready = !busy && axi_req.w_valid;
  assign axi_rsp.w_ready  = !busy && axi_req.aw_valid;
  assign axi_rsp.ar_ready = !busy && !aw_w_both;
  assign axi_rsp.b_valid  = b_valid_q;
  assign axi_rsp.r_valid  = r_valid_q;
  assign axi_rsp.r_data   = r_data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy      <= 1'b0;
      cnt       <= '0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_go || rd_go) begin
        busy  <= 1'b1;
        wr_q  <= wr_go;
        idx_q <= wr_go ? wr_idx : rd_idx;
        cnt   <= SRAM_CNT_W'(SRAM_LATENCY);
      end else if (busy && cnt != '0) begin
        cnt <= cnt - 1'b1;
        // last count raises the response
        if (cnt == SRAM_CNT_W'(1)) begin
          if (wr_q) begin
            b_valid_q <= 1'b1;
          end else begin
            r_valid_q <= 1'b1;
            r_data_q  <= mem[idx_q];
          end
        end
      end

      if (b_valid_q && axi_req.b_ready) begin
        b_valid_q <= 1'b0;
        busy      <= 1'b0;
      end
      if (r_valid_q && axi_req.r_ready) begin
        r_valid_q <= 1'b0;
        busy      <= 1'b0;
      end
    end
  end

  // byte-enable write at acceptance
  always_ff @(posedge clock) begin
    if (wr_go) begin
      for (int b = 0; b < 4; b++) begin
        if (axi_req.w_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= axi_req.w_data[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- dcache/dcu.sv
`timescale 1ns/1ps

module dcu
  import dcu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  lsu_req_t req,
  input  logic     req_valid,
  output logic     req_ready,
  output lsu_rsp_t rsp,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output axi_req_t axi_req,
  input  axi_rsp_t axi_rsp
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WB,     // held bytes going out
    S_FILL,   // full word coming in
    S_UNC,    // single uncached beat
    S_RESP
  } state_e;

  state_e   state;
  lsu_req_t req_q;
  lsu_rsp_t rsp_q;
  dline_t   line;
  axi_req_t axi_q;

  logic [3:0]      req_strb;
  logic [XLEN-1:0] req_lane;
  logic [XLEN-1:0] hit_merged;
  logic [XLEN-1:0] hit_load;
  logic [3:0]      q_strb;
  logic [XLEN-1:0] q_merged;
  logic [XLEN-1:0] axi_load;

  logic cacheable;
  logic tag_match;
  logic covered;
  logic dirty;
  logic load_hit;
  logic store_hit;

  // incoming request against the line
  byte_lane_align u_align_req (
    .addr       (req.addr),
    .size       (req.size),
    .wdata      (req.wdata),
    .line_data  (line.data),
    .mem_word   (line.data),
    .strb       (req_strb),
    .wdata_lane (req_lane),
    .merged     (hit_merged),
    .load_data  (hit_load)
  );

  // registered request against bus data
  byte_lane_align u_align_axi (
    .addr       (req_q.addr),
    .size       (req_q.size),
    .wdata      (req_q.wdata),
    .line_data  (line.data),
    .mem_word   (axi_rsp.r_data),
    .strb       (q_strb),
    .wdata_lane (),
    .merged     (q_merged),
    .load_data  (axi_load)
  );

  assign cacheable = req.addr >= CACHE_BASE;
  assign tag_match = line.valid && (line.tag == req.addr[XLEN-1:2]);
  assign covered   = (req_strb & ~line.held) == 4'b0000;  // every needed byte present
  assign dirty     = line.valid && (line.held != 4'b0000);
  assign load_hit  = cacheable && (req.op == OP_LOAD) && tag_match && covered;
  assign store_hit = cacheable && (req.op == OP_STORE) && (tag_match || !line.valid);

  assign req_ready = (state == S_IDLE);
  assign rsp_valid = (state == S_RESP);
  assign rsp       = rsp_q;
  assign axi_req   = axi_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state          <= S_IDLE;
      line.valid     <= 1'b0;
      line.held      <= 4'b0000;
      axi_q.aw_valid <= 1'b0;
      axi_q.w_valid  <= 1'b0;
      axi_q.b_ready  <= 1'b0;
      axi_q.ar_valid <= 1'b0;
      axi_q.r_ready  <= 1'b0;
    end else begin
      unique case (state)
        S_IDLE: begin
          if (req_valid) begin
            req_q       <= req;
            rsp_q.rdata <= '0;
            if (req.op != OP_FLUSH && !cacheable) begin
              if (req.op == OP_STORE) begin
                axi_q.aw_valid <= 1'b1;
                axi_q.w_valid  <= 1'b1;
                axi_q.b_ready  <= 1'b1;
                axi_q.aw_addr  <= req.addr;
                axi_q.aw_size  <= {1'b0, req.size};
                axi_q.w_data   <= req_lane;
                axi_q.w_strb   <= req_strb;
              end else begin
                axi_q.ar_valid <= 1'b1;
                axi_q.r_ready  <= 1'b1;
                axi_q.ar_addr  <= req.addr;
                axi_q.ar_size  <= {1'b0, req.size};
              end
              state <= S_UNC;
            end else if (load_hit) begin
              rsp_q.rdata <= hit_load;
              state       <= S_RESP;
            end else if (store_hit) begin
              line.valid <= 1'b1;
              line.tag   <= req.addr[XLEN-1:2];
              line.data  <= hit_merged;
              line.held  <= line.held | req_strb;
              state      <= S_RESP;
            end else if (dirty) begin
              // push out what the line owns first
              axi_q.aw_valid <= 1'b1;
              axi_q.w_valid  <= 1'b1;
              axi_q.b_ready  <= 1'b1;
              axi_q.aw_addr  <= {line.tag, 2'b00};
              axi_q.aw_size  <= 3'd2;
              axi_q.w_data   <= line.data;
              axi_q.w_strb   <= line.held;
              state          <= S_WB;
            end else if (req.op == OP_LOAD) begin
              axi_q.ar_valid <= 1'b1;
              axi_q.r_ready  <= 1'b1;
              axi_q.ar_addr  <= {req.addr[XLEN-1:2], 2'b00};
              axi_q.ar_size  <= 3'd2;
              state          <= S_FILL;
            end else if (req.op == OP_FLUSH) begin
              line.valid <= 1'b0;  // nothing to write back
              line.held  <= 4'b0000;
              state      <= S_RESP;
            end else begin
              line.valid <= 1'b1;
              line.tag   <= req.addr[XLEN-1:2];
              line.data  <= hit_merged;
              line.held  <= req_strb;
              state      <= S_RESP;
            end
          end
        end

        S_WB: begin
          if (axi_rsp.aw_ready) axi_q.aw_valid <= 1'b0;
          if (axi_rsp.w_ready)  axi_q.w_valid  <= 1'b0;
          if (axi_rsp.b_valid && axi_q.b_ready) begin
            axi_q.b_ready <= 1'b0;
            line.held     <= 4'b0000;  // memory has them now
            unique case (req_q.op)
              OP_LOAD: begin
                axi_q.ar_valid <= 1'b1;
                axi_q.r_ready  <= 1'b1;
                axi_q.ar_addr  <= {req_q.addr[XLEN-1:2], 2'b00};
                axi_q.ar_size  <= 3'd2;
                state          <= S_FILL;
              end
              OP_STORE: begin
                // new tag owns only the stored bytes
                line.valid <= 1'b1;
                line.tag   <= req_q.addr[XLEN-1:2];
                line.data  <= q_merged;
                line.held  <= q_strb;
                state      <= S_RESP;
              end
              default: begin
                line.valid <= 1'b0;
                state      <= S_RESP;
              end
            endcase
          end
        end

        S_FILL: begin
          if (axi_rsp.ar_ready) axi_q.ar_valid <= 1'b0;
          if (axi_rsp.r_valid && axi_q.r_ready) begin
            axi_q.r_ready <= 1'b0;
            line.valid    <= 1'b1;
            line.held     <= 4'b1111;
            line.tag      <= req_q.addr[XLEN-1:2];
            line.data     <= axi_rsp.r_data;
            rsp_q.rdata   <= axi_load;
            state         <= S_RESP;
          end
        end

        S_UNC: begin
          if (axi_rsp.aw_ready) axi_q.aw_valid <= 1'b0;
          if (axi_rsp.w_ready)  axi_q.w_valid  <= 1'b0;
          if (axi_rsp.ar_ready) axi_q.ar_valid <= 1'b0;
          if (axi_rsp.b_valid && axi_q.b_ready) begin
            axi_q.b_ready <= 1'b0;
            state         <= S_RESP;
          end
          if (axi_rsp.r_valid && axi_q.r_ready) begin
            axi_q.r_ready <= 1'b0;
            rsp_q.rdata   <= axi_load;
            state         <= S_RESP;
          end
        end

        S_RESP: begin
          if (rsp_ready) state <= S_IDLE;  // held until taken
        end

        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- dcache/byte_lane_align.sv
`timescale 1ns/1ps

module byte_lane_align
  import dcu_pkg::*;
(
  input  logic [31:0] addr,
  input  mem_size_e   size,
  input  logic [31:0] wdata,
  input  logic [31:0] line_data,
  input  logic [31:0] mem_word,
  output logic [3:0]  strb,
  output logic [31:0] wdata_lane,
  output logic [31:0] merged,
  output logic [31:0] load_data
);

  logic [3:0]  base_strb;
  logic [31:0] lane_mask;
  logic [31:0] word_shifted;
  logic [31:0] ext_mask;

  // strobe and result width by access size
  always_comb begin
    unique case (size)
      SZ_BYTE: begin
        base_strb = 4'b0001;
        ext_mask  = 32'h0000_00ff;
      end
      SZ_HALF: begin
        base_strb = 4'b0011;
        ext_mask  = 32'h0000_ffff;
      end
      default: begin
        base_strb = 4'b1111;
        ext_mask  = 32'hffff_ffff;
      end
    endcase
  end

  assign strb       = base_strb << addr[1:0];
  assign wdata_lane = wdata << {addr[1:0], 3'b000};

  // one byte of mask per strobe bit
  assign lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  assign merged    = (line_data & ~lane_mask) | (wdata_lane & lane_mask);

  // addressed bytes down to bit 0, upper bits cleared
  assign word_shifted = mem_word >> {addr[1:0], 3'b000};
  assign load_data    = word_shifted & ext_mask;

endmodule

//--- common/dcu_pkg.sv
package dcu_pkg;

  // data and address width
  localparam int XLEN = 32;

  // everything from here up goes through the line
  localparam logic [XLEN-1:0] CACHE_BASE = 32'ha000_0000;

  localparam int MEM_WORDS    = 1024;
  localparam int SRAM_LATENCY = 3;   // accepted address to response

  // derived widths for the memory model
  localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
  localparam int SRAM_CNT_W = $clog2(SRAM_LATENCY + 1);

  typedef enum logic [1:0] {
    OP_LOAD,
    OP_STORE,
    OP_FLUSH   // write back and drop the line
  } mem_op_e;

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD
  } mem_size_e;

  typedef struct packed {
    mem_op_e         op;
    mem_size_e       size;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;   // low bits, not yet in lane position
  } lsu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;   // zero-extended load result
  } lsu_rsp_t;

  typedef struct packed {
    logic            valid;
    logic [3:0]      held;    // bytes owned by the line
    logic [29:0]     tag;     // word address
    logic [XLEN-1:0] data;
  } dline_t;

  // master to slave, single beats only
  typedef struct packed {
    logic            aw_valid;
    logic [XLEN-1:0] aw_addr;
    logic [2:0]      aw_size;
    logic            w_valid;
    logic [XLEN-1:0] w_data;
    logic [3:0]      w_strb;
    logic            b_ready;
    logic            ar_valid;
    logic [XLEN-1:0] ar_addr;
    logic [2:0]      ar_size;
    logic            r_ready;
  } axi_req_t;

  typedef struct packed {
    logic            aw_ready;
    logic            w_ready;
    logic            b_valid;
    logic            ar_ready;
    logic            r_valid;
    logic [XLEN-1:0] r_data;
  } axi_rsp_t;

endpackage
